//--- include/rv_core_defines.svh
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// RV32I major opcodes for the supported subset.
`define RV_OPC_OP       7'b0110011
`define RV_OPC_OPIMM    7'b0010011
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_AUIPC    7'b0010111
`define RV_OPC_JAL      7'b1101111
`define RV_OPC_JALR     7'b1100111
`define RV_OPC_SYSTEM   7'b1110011

// Implemented machine CSRs.
`define RV_CSR_MSCRATCH 12'h340
`define RV_CSR_MTVEC    12'h305

`define RV_NREGS        32  // Integer register count.

`endif

//--- rtl/rv_core_pkg.sv
package rv_core_pkg;

    typedef logic [31:0] word_t;      // PC, operands, immediates, results.
    typedef logic [4:0]  reg_addr_t;  // Integer register index.
    typedef logic [11:0] csr_addr_t;  // CSR address.

    // Execute stage operations.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_t;

    // Operand pairs fed to the ALU.
    typedef enum logic [1:0] {
        src_reg = 2'b00,  // rs1 with rs2 or CSR value.
        src_imm = 2'b01,  // rs1 with immediate.
        src_pc4 = 2'b10,  // PC with 4.
        src_pci = 2'b11   // PC with immediate.
    } src_sel_t;

endpackage

//--- rtl/rv_decoder.sv
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_decoder (
    input  rv_core_pkg::word_t     i_instr,
    output rv_core_pkg::reg_addr_t o_rs1,
    output rv_core_pkg::reg_addr_t o_rs2,
    output rv_core_pkg::reg_addr_t o_rd,
    output rv_core_pkg::word_t     o_imm,
    output rv_core_pkg::alu_op_t   o_alu_op,
    output rv_core_pkg::src_sel_t  o_src_sel,
    output logic                   o_csr_sel,
    output logic                   o_csr_wen,
    output logic                   o_wen,
    output logic                   o_legal,
    output rv_core_pkg::csr_addr_t o_csr_addr
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    rv_core_pkg::word_t   imm_i;
    rv_core_pkg::word_t   imm_u;
    rv_core_pkg::word_t   imm_j;
    rv_core_pkg::alu_op_t funct_op;

    assign opcode     = i_instr[6:0];
    assign funct3     = i_instr[14:12];
    assign funct7     = i_instr[31:25];
    assign o_rs2      = i_instr[24:20];
    assign o_rd       = i_instr[11:7];
    assign o_csr_addr = i_instr[31:20];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    // Common to OP and OP-IMM. Sub only exists in the register form.
    always_comb begin
        case (funct3)
            3'b000: begin
                if (opcode == `RV_OPC_OP && funct7[5]) funct_op = rv_core_pkg::alu_sub;
                else                                   funct_op = rv_core_pkg::alu_add;
            end
            3'b001: funct_op = rv_core_pkg::alu_sll;
            3'b010: funct_op = rv_core_pkg::alu_slt;
            3'b011: funct_op = rv_core_pkg::alu_sltu;
            3'b100: funct_op = rv_core_pkg::alu_xor;
            3'b101: begin
                if (funct7[5]) funct_op = rv_core_pkg::alu_sra;
                else           funct_op = rv_core_pkg::alu_srl;
            end
            3'b110: funct_op = rv_core_pkg::alu_or;
            default: funct_op = rv_core_pkg::alu_and;
        endcase
    end

    always_comb begin
        o_rs1     = i_instr[19:15];
        o_imm     = imm_i;
        o_alu_op  = rv_core_pkg::alu_add;
        o_src_sel = rv_core_pkg::src_reg;
        o_csr_sel = 1'b0;
        o_csr_wen = 1'b0;
        o_wen     = 1'b0;
        o_legal   = 1'b0;
        case (opcode)
            `RV_OPC_OP: begin
                o_alu_op = funct_op;
                o_wen    = 1'b1;
                o_legal  = (funct7 == 7'b0000000) ||
                           (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            `RV_OPC_OPIMM: begin
                o_alu_op  = funct_op;
                o_src_sel = rv_core_pkg::src_imm;
                o_wen     = 1'b1;
                case (funct3)
                    3'b001:  o_legal = (funct7 == 7'b0000000);
                    3'b101:  o_legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    default: o_legal = 1'b1;
                endcase
            end
            `RV_OPC_LUI: begin
                o_rs1     = '0;  // x0 + imm.
                o_imm     = imm_u;
                o_src_sel = rv_core_pkg::src_imm;
                o_wen     = 1'b1;
                o_legal   = 1'b1;
            end
            `RV_OPC_AUIPC: begin
                o_imm     = imm_u;
                o_src_sel = rv_core_pkg::src_pci;
                o_wen     = 1'b1;
                o_legal   = 1'b1;
            end
            `RV_OPC_JAL: begin
                o_imm     = imm_j;
                o_src_sel = rv_core_pkg::src_pc4;  // Link value only.
                o_wen     = 1'b1;
                o_legal   = 1'b1;
            end
            `RV_OPC_JALR: begin
                o_src_sel = rv_core_pkg::src_pc4;
                o_wen     = 1'b1;
                o_legal   = (funct3 == 3'b000);
            end
            `RV_OPC_SYSTEM: begin
                // CSRRW only. Old CSR value goes to rd.
                o_alu_op  = rv_core_pkg::alu_pass_b;
                o_csr_sel = 1'b1;
                o_csr_wen = 1'b1;
                o_wen     = 1'b1;
                o_legal   = (funct3 == 3'b001);
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_regfile (
    input                          clock,
    input                          reset,
    input  rv_core_pkg::reg_addr_t i_rs1,
    input  rv_core_pkg::reg_addr_t i_rs2,
    input  rv_core_pkg::reg_addr_t i_wr_addr,
    input                          i_wr_en,
    input  rv_core_pkg::word_t     i_wr_data,
    output rv_core_pkg::word_t     o_rs1_data,
    output rv_core_pkg::word_t     o_rs2_data
);

    rv_core_pkg::word_t regs [1:`RV_NREGS-1];  // No storage for x0.

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_addr != '0) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Write data bypasses the array for a same-cycle read.
    function automatic rv_core_pkg::word_t read_port(input rv_core_pkg::reg_addr_t addr);
        if (addr == '0) return '0;
        if (i_wr_en && addr == i_wr_addr) return i_wr_data;
        return regs[addr];
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

endmodule

//--- rtl/rv_csr_file.sv
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_csr_file (
    input                          clock,
    input                          reset,
    input  rv_core_pkg::csr_addr_t i_rd_addr,
    input  rv_core_pkg::csr_addr_t i_wr_addr,
    input                          i_wr_en,
    input  rv_core_pkg::word_t     i_wr_data,
    output rv_core_pkg::word_t     o_rd_data,
    output logic                   o_rd_hit
);

    rv_core_pkg::word_t mscratch;
    rv_core_pkg::word_t mtvec;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mscratch <= '0;
            mtvec    <= '0;
        end else if (i_wr_en) begin
            case (i_wr_addr)
                `RV_CSR_MSCRATCH: mscratch <= i_wr_data;
                `RV_CSR_MTVEC:    mtvec    <= i_wr_data;
                default: ;
            endcase
        end
    end

    always_comb begin
        o_rd_hit = 1'b1;
        case (i_rd_addr)
            `RV_CSR_MSCRATCH: o_rd_data = mscratch;
            `RV_CSR_MTVEC:    o_rd_data = mtvec;
            default: begin
                o_rd_data = '0;
                o_rd_hit  = 1'b0;  // Unknown CSR.
            end
        endcase
        // Execute-stage write is visible to the read in the same cycle.
        if (o_rd_hit && i_wr_en && i_wr_addr == i_rd_addr) o_rd_data = i_wr_data;
    end

endmodule

//--- rtl/rv_idex_regs.sv
`timescale 1ns/100ps

module rv_idex_regs (
    input                                clock,
    input                                reset,
    input                                i_valid,
    input  rv_core_pkg::word_t           i_pc,
    input  rv_core_pkg::word_t           i_imm,
    input  rv_core_pkg::word_t           i_src1,
    input  rv_core_pkg::word_t           i_src2,
    input  rv_core_pkg::word_t           i_csr_data,
    input                                i_csr_sel,
    input  rv_core_pkg::src_sel_t        i_src_sel,
    input  rv_core_pkg::alu_op_t         i_alu_op,
    input  rv_core_pkg::reg_addr_t       i_rd,
    input                                i_wen,
    input                                i_csr_wen,
    input  rv_core_pkg::csr_addr_t       i_csr_addr,
    output logic                         o_valid,
    output rv_core_pkg::word_t           o_alu_rs1,
    output rv_core_pkg::word_t           o_alu_rs2,
    output rv_core_pkg::word_t           o_csr_wdata,
    output rv_core_pkg::alu_op_t         o_alu_op,
    output rv_core_pkg::reg_addr_t       o_rd,
    output logic                         o_wen,
    output logic                         o_csr_wen,
    output rv_core_pkg::csr_addr_t       o_csr_addr
);

    rv_core_pkg::word_t alu_src1;
    rv_core_pkg::word_t alu_src2;

    always_comb begin
        case (i_src_sel)
            rv_core_pkg::src_pc4,
            rv_core_pkg::src_pci: alu_src1 = i_pc;
            default:              alu_src1 = i_src1;
        endcase
        case (i_src_sel)
            rv_core_pkg::src_reg: alu_src2 = i_csr_sel ? i_csr_data : i_src2;
            rv_core_pkg::src_pc4: alu_src2 = 32'd4;
            default:              alu_src2 = i_imm;  // imm and pci.
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            o_valid   <= 1'b0;
            o_wen     <= 1'b0;
            o_csr_wen <= 1'b0;
        end else begin
            o_valid   <= i_valid;
            o_wen     <= i_wen;
            o_csr_wen <= i_csr_wen;
        end
    end

    always_ff @(posedge clock) begin
        o_alu_rs1   <= alu_src1;
        o_alu_rs2   <= alu_src2;
        o_csr_wdata <= i_src1;  // New CSR value for CSRRW.
        o_alu_op    <= i_alu_op;
        o_rd        <= i_rd;
        o_csr_addr  <= i_csr_addr;
    end

endmodule

//--- rtl/rv_alu_stage.sv
`timescale 1ns/100ps

module rv_alu_stage (
    input                                clock,
    input                                reset,
    input                                i_valid,
    input  rv_core_pkg::word_t           i_alu_rs1,
    input  rv_core_pkg::word_t           i_alu_rs2,
    input  rv_core_pkg::alu_op_t         i_alu_op,
    input  rv_core_pkg::reg_addr_t       i_rd,
    input                                i_wen,
    input                                i_csr_wen,
    input  rv_core_pkg::csr_addr_t       i_csr_addr,
    input  rv_core_pkg::word_t           i_csr_wdata,
    output logic                         o_rf_wr_en,
    output rv_core_pkg::reg_addr_t       o_rf_wr_addr,
    output rv_core_pkg::word_t           o_rf_wr_data,
    output logic                         o_csr_wr_en,
    output rv_core_pkg::csr_addr_t       o_csr_wr_addr,
    output rv_core_pkg::word_t           o_csr_wr_data,
    output logic                         o_wb_valid,
    output rv_core_pkg::reg_addr_t       o_wb_rd,
    output rv_core_pkg::word_t           o_wb_data
);

    rv_core_pkg::word_t result;
    logic [4:0]         shamt;

    assign shamt = i_alu_rs2[4:0];

    always_comb begin
        case (i_alu_op)
            rv_core_pkg::alu_sub:  result = i_alu_rs1 - i_alu_rs2;
            rv_core_pkg::alu_and:  result = i_alu_rs1 & i_alu_rs2;
            rv_core_pkg::alu_or:   result = i_alu_rs1 | i_alu_rs2;
            rv_core_pkg::alu_xor:  result = i_alu_rs1 ^ i_alu_rs2;
            rv_core_pkg::alu_slt:  result = {31'b0, $signed(i_alu_rs1) < $signed(i_alu_rs2)};
            rv_core_pkg::alu_sltu: result = {31'b0, i_alu_rs1 < i_alu_rs2};
            rv_core_pkg::alu_sll:  result = i_alu_rs1 << shamt;
            rv_core_pkg::alu_srl:  result = i_alu_rs1 >> shamt;
            rv_core_pkg::alu_sra:  result = $signed(i_alu_rs1) >>> shamt;
            rv_core_pkg::alu_pass_b: result = i_alu_rs2;
            default:               result = i_alu_rs1 + i_alu_rs2;
        endcase
    end

    // Write ports, committed at the end of the execute cycle.
    assign o_rf_wr_en    = i_valid && i_wen && (i_rd != '0);
    assign o_rf_wr_addr  = i_rd;
    assign o_rf_wr_data  = result;
    assign o_csr_wr_en   = i_valid && i_csr_wen;
    assign o_csr_wr_addr = i_csr_addr;
    assign o_csr_wr_data = i_csr_wdata;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            o_wb_valid <= 1'b0;
            o_wb_rd    <= '0;
            o_wb_data  <= '0;
        end else begin
            o_wb_valid <= o_rf_wr_en;
            o_wb_rd    <= i_rd;
            o_wb_data  <= result;
        end
    end

endmodule

//--- rtl/rv_core_slice_top.sv
`timescale 1ns/100ps

module rv_core_slice_top (
    input                          clock,
    input                          reset,
    input                          i_instr_valid,
    input  rv_core_pkg::word_t     i_instr,
    input  rv_core_pkg::word_t     i_pc,
    output logic                   o_wb_valid,
    output rv_core_pkg::reg_addr_t o_wb_rd,
    output rv_core_pkg::word_t     o_wb_data
);

    // Decode outputs.
    rv_core_pkg::reg_addr_t dec_rs1;
    rv_core_pkg::reg_addr_t dec_rs2;
    rv_core_pkg::reg_addr_t dec_rd;
    rv_core_pkg::word_t     dec_imm;
    rv_core_pkg::alu_op_t   dec_alu_op;
    rv_core_pkg::src_sel_t  dec_src_sel;
    logic                   dec_csr_sel;
    logic                   dec_csr_wen;
    logic                   dec_wen;
    logic                   dec_legal;
    rv_core_pkg::csr_addr_t dec_csr_addr;
    logic                   dec_valid;

    rv_core_pkg::word_t     rs1_data;
    rv_core_pkg::word_t     rs2_data;
    rv_core_pkg::word_t     csr_data;
    logic                   csr_hit;

    // Decode/execute register outputs.
    logic                   ex_valid;
    rv_core_pkg::word_t     ex_alu_rs1;
    rv_core_pkg::word_t     ex_alu_rs2;
    rv_core_pkg::word_t     ex_csr_wdata;
    rv_core_pkg::alu_op_t   ex_alu_op;
    rv_core_pkg::reg_addr_t ex_rd;
    logic                   ex_wen;
    logic                   ex_csr_wen;
    rv_core_pkg::csr_addr_t ex_csr_addr;

    // Execute write ports.
    logic                   rf_wr_en;
    rv_core_pkg::reg_addr_t rf_wr_addr;
    rv_core_pkg::word_t     rf_wr_data;
    logic                   csr_wr_en;
    rv_core_pkg::csr_addr_t csr_wr_addr;
    rv_core_pkg::word_t     csr_wr_data;

    // Illegal opcode or missing CSR becomes a bubble.
    assign dec_valid = i_instr_valid && dec_legal && (!dec_csr_sel || csr_hit);

    rv_decoder u_decoder (
        .i_instr    (i_instr),
        .o_rs1      (dec_rs1),
        .o_rs2      (dec_rs2),
        .o_rd       (dec_rd),
        .o_imm      (dec_imm),
        .o_alu_op   (dec_alu_op),
        .o_src_sel  (dec_src_sel),
        .o_csr_sel  (dec_csr_sel),
        .o_csr_wen  (dec_csr_wen),
        .o_wen      (dec_wen),
        .o_legal    (dec_legal),
        .o_csr_addr (dec_csr_addr)
    );

    rv_regfile u_regfile (
        .clock      (clock),
        .reset      (reset),
        .i_rs1      (dec_rs1),
        .i_rs2      (dec_rs2),
        .i_wr_addr  (rf_wr_addr),
        .i_wr_en    (rf_wr_en),
        .i_wr_data  (rf_wr_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_csr_file u_csr_file (
        .clock     (clock),
        .reset     (reset),
        .i_rd_addr (dec_csr_addr),
        .i_wr_addr (csr_wr_addr),
        .i_wr_en   (csr_wr_en),
        .i_wr_data (csr_wr_data),
        .o_rd_data (csr_data),
        .o_rd_hit  (csr_hit)
    );

    rv_idex_regs u_idex_regs (
        .clock       (clock),
        .reset       (reset),
        .i_valid     (dec_valid),
        .i_pc        (i_pc),
        .i_imm       (dec_imm),
        .i_src1      (rs1_data),
        .i_src2      (rs2_data),
        .i_csr_data  (csr_data),
        .i_csr_sel   (dec_csr_sel),
        .i_src_sel   (dec_src_sel),
        .i_alu_op    (dec_alu_op),
        .i_rd        (dec_rd),
        .i_wen       (dec_wen),
        .i_csr_wen   (dec_csr_wen),
        .i_csr_addr  (dec_csr_addr),
        .o_valid     (ex_valid),
        .o_alu_rs1   (ex_alu_rs1),
        .o_alu_rs2   (ex_alu_rs2),
        .o_csr_wdata (ex_csr_wdata),
        .o_alu_op    (ex_alu_op),
        .o_rd        (ex_rd),
        .o_wen       (ex_wen),
        .o_csr_wen   (ex_csr_wen),
        .o_csr_addr  (ex_csr_addr)
    );

    rv_alu_stage u_alu_stage (
        .clock         (clock),
        .reset         (reset),
        .i_valid       (ex_valid),
        .i_alu_rs1     (ex_alu_rs1),
        .i_alu_rs2     (ex_alu_rs2),
        .i_alu_op      (ex_alu_op),
        .i_rd          (ex_rd),
        .i_wen         (ex_wen),
        .i_csr_wen     (ex_csr_wen),
        .i_csr_addr    (ex_csr_addr),
        .i_csr_wdata   (ex_csr_wdata),
        .o_rf_wr_en    (rf_wr_en),
        .o_rf_wr_addr  (rf_wr_addr),
        .o_rf_wr_data  (rf_wr_data),
        .o_csr_wr_en   (csr_wr_en),
        .o_csr_wr_addr (csr_wr_addr),
        .o_csr_wr_data (csr_wr_data),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data)
    );

endmodule

//--- tb/rv_core_slice_chk.sv
`timescale 1ns/100ps

module rv_core_slice_chk (
    input                          clock,
    input                          reset,
    input                          i_dec_valid,
    input                          i_dec_wen,
    input  rv_core_pkg::reg_addr_t i_dec_rd,
    input                          i_wb_valid,
    input  rv_core_pkg::reg_addr_t i_wb_rd
);

    int   fail_count = 0;
    logic wb_expected;

    // Decoded instruction that must show up on the writeback port.
    assign wb_expected = i_dec_valid && i_dec_wen && (i_dec_rd != '0);

    wb_low_in_reset: assert property (@(posedge clock) reset |-> !i_wb_valid)
        else begin
            fail_count++;
            $error("Writeback valid high during reset.");
        end

    // Pipeline is empty for two cycles after reset.
    wb_low_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !i_wb_valid ##1 !i_wb_valid)
        else begin
            fail_count++;
            $error("Writeback valid high right after reset.");
        end

    wb_latency: assert property (@(posedge clock) disable iff (reset)
        wb_expected |-> ##2 i_wb_valid)
        else begin
            fail_count++;
            $error("Writeback missing two cycles after a writing instruction.");
        end

    wb_no_spurious: assert property (@(posedge clock) disable iff (reset)
        !wb_expected |-> ##2 !i_wb_valid)
        else begin
            fail_count++;
            $error("Writeback valid without a writing instruction.");
        end

    wb_rd_nonzero: assert property (@(posedge clock) disable iff (reset)
        i_wb_valid |-> i_wb_rd != '0)
        else begin
            fail_count++;
            $error("Writeback to x0.");
        end

endmodule

bind rv_core_slice_top rv_core_slice_chk u_chk (
    .clock       (clock),
    .reset       (reset),
    .i_dec_valid (dec_valid),
    .i_dec_wen   (dec_wen),
    .i_dec_rd    (dec_rd),
    .i_wb_valid  (o_wb_valid),
    .i_wb_rd     (o_wb_rd)
);

//--- tb/tb_rv_core_slice.sv
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module tb_rv_core_slice;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_INSTR  = 400;

    logic                   clock;
    logic                   reset;
    logic                   instr_valid;
    rv_core_pkg::word_t     instr;
    rv_core_pkg::word_t     pc;
    logic                   wb_valid;
    rv_core_pkg::reg_addr_t wb_rd;
    rv_core_pkg::word_t     wb_data;

    rv_core_pkg::word_t     model_regs [`RV_NREGS];
    rv_core_pkg::word_t     model_mscratch;
    rv_core_pkg::word_t     model_mtvec;
    logic [31:0]            rand_state = 32'd68;

    // Expected writeback, one entry per driven cycle.
    logic                   exp_valid_q [$];
    rv_core_pkg::reg_addr_t exp_rd_q [$];
    rv_core_pkg::word_t     exp_data_q [$];

    rv_core_slice_top i_dut (
        .clock         (clock),
        .reset         (reset),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .i_pc          (pc),
        .o_wb_valid    (wb_valid),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state ^ (rand_state >> 15);
    endfunction

    // Small register indices keep dependencies frequent.
    function automatic rv_core_pkg::word_t random_instr();
        logic [31:0] r;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] csr;
        r   = next_random();
        r2  = next_random();
        rd  = {2'b0, r[2:0]};
        rs1 = {2'b0, r[5:3]};
        rs2 = {2'b0, r[8:6]};
        f3  = r[11:9];
        f7  = r[12] ? 7'b0100000 : 7'b0000000;
        csr = r2[1] ? `RV_CSR_MSCRATCH : `RV_CSR_MTVEC;
        if (r2[5:2] == 4'd0) csr = 12'h300;  // Not implemented.
        case (r[31:28])
            4'd0, 4'd1, 4'd2: return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
            4'd3, 4'd4, 4'd5: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    return {f7, r2[4:0], rs1, f3, rd, `RV_OPC_OPIMM};
                end
                return {r2[11:0], rs1, f3, rd, `RV_OPC_OPIMM};
            end
            4'd6:  return {r2[19:0], rd, `RV_OPC_LUI};
            4'd7:  return {r2[19:0], rd, `RV_OPC_AUIPC};
            4'd8:  return {r2[19:0], rd, `RV_OPC_JAL};
            4'd9:  return {r2[11:0], rs1, 3'b000, rd, `RV_OPC_JALR};
            4'd10, 4'd11, 4'd12: return {csr, rs1, 3'b001, rd, `RV_OPC_SYSTEM};
            4'd13: return {r2[31:7], 7'b0000011};  // Load, unsupported.
            default: return r2;
        endcase
    endfunction

    function automatic rv_core_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                                     input rv_core_pkg::word_t a,
                                                     input rv_core_pkg::word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // In-order ISA model. Results are known at decode and due 2 cycles later.
    task automatic model_step(input logic valid, input rv_core_pkg::word_t word,
                              input rv_core_pkg::word_t pc_val);
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [4:0]         rd;
        logic [11:0]        csr;
        logic               alt;
        logic               legal;
        rv_core_pkg::word_t a;
        rv_core_pkg::word_t b;
        rv_core_pkg::word_t result;
        opc    = word[6:0];
        f3     = word[14:12];
        f7     = word[31:25];
        rd     = word[11:7];
        csr    = word[31:20];
        a      = model_regs[word[19:15]];
        b      = model_regs[word[24:20]];
        alt    = word[30] && (f3 == 3'b101 || (opc == `RV_OPC_OP && f3 == 3'b000));
        legal  = 1'b1;
        result = '0;
        case (opc)
            `RV_OPC_OP: begin
                legal  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                result = alu_model(f3, alt, a, b);
            end
            `RV_OPC_OPIMM: begin
                if (f3 == 3'b001) legal = (f7 == 7'h00);
                if (f3 == 3'b101) legal = (f7 == 7'h00) || (f7 == 7'h20);
                result = alu_model(f3, alt, a, {{20{word[31]}}, word[31:20]});
            end
            `RV_OPC_LUI:   result = {word[31:12], 12'b0};
            `RV_OPC_AUIPC: result = pc_val + {word[31:12], 12'b0};
            `RV_OPC_JAL:   result = pc_val + 32'd4;
            `RV_OPC_JALR: begin
                legal  = (f3 == 3'b000);
                result = pc_val + 32'd4;
            end
            `RV_OPC_SYSTEM: begin
                legal  = (f3 == 3'b001) && (csr == `RV_CSR_MSCRATCH || csr == `RV_CSR_MTVEC);
                result = (csr == `RV_CSR_MSCRATCH) ? model_mscratch : model_mtvec;
                if (valid && legal && csr == `RV_CSR_MSCRATCH) model_mscratch = a;
                if (valid && legal && csr == `RV_CSR_MTVEC) model_mtvec = a;
            end
            default: legal = 1'b0;
        endcase
        exp_valid_q.push_back(valid && legal && rd != '0);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(result);
        if (valid && legal && rd != '0) model_regs[rd] = result;
    endtask

    task automatic check_writeback();
        logic                   exp_valid;
        rv_core_pkg::reg_addr_t exp_rd;
        rv_core_pkg::word_t     exp_data;
        exp_valid = exp_valid_q.pop_front();
        exp_rd    = exp_rd_q.pop_front();
        exp_data  = exp_data_q.pop_front();
        assert (wb_valid === exp_valid)
            else fail_run($sformatf("** Error at %0t: wb valid %b, expected %b",
                                    $time, wb_valid, exp_valid));
        if (exp_valid) begin
            assert (wb_rd === exp_rd)
                else fail_run($sformatf("** Error at %0t: wb rd %0d, expected %0d",
                                        $time, wb_rd, exp_rd));
            assert (wb_data === exp_data)
                else fail_run($sformatf("** Error at %0t: wb data %h, expected %h",
                                        $time, wb_data, exp_data));
        end
        assert (i_dut.u_chk.fail_count == 0)
            else fail_run("A bound timing assertion on the DUT failed.");
    endtask

    initial begin
        #((NUM_INSTR + 100) * CLK_PERIOD);
        fail_run("Timeout: the instruction stream did not drain in time.");
    end

    initial begin
        logic [31:0]        r;
        logic               valid;
        rv_core_pkg::word_t word;
        rv_core_pkg::word_t pc_val;
        clock          = 1'b0;
        reset          = 1'b1;
        instr_valid    = 1'b0;
        instr          = '0;
        pc             = '0;
        model_mscratch = '0;
        model_mtvec    = '0;
        for (int i = 0; i < `RV_NREGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        // Two trailing bubbles drain the pipeline.
        for (int n = 0; n < NUM_INSTR + 2; n++) begin
            r           = next_random();
            word        = random_instr();
            pc_val      = next_random() & 32'hffff_fffc;
            valid       = (n < NUM_INSTR) && (r[27:25] != 3'd0);
            instr_valid = valid;
            instr       = word;
            pc          = pc_val;
            model_step(valid, word, pc_val);
            @(negedge clock);
            if (exp_valid_q.size() > 2) check_writeback();
            @(posedge clock);
            #2;
        end
        if (i_dut.u_chk.fail_count != 0) begin
            fail_run("A bound timing assertion on the DUT failed.");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- sources.f
+incdir+include
rtl/rv_core_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_csr_file.sv
rtl/rv_idex_regs.sv
rtl/rv_alu_stage.sv
rtl/rv_core_slice_top.sv
tb/rv_core_slice_chk.sv
tb/tb_rv_core_slice.sv

//--- Bender.yml
package:
  name: rv_core_slice

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rv_core_pkg.sv
      - rtl/rv_decoder.sv
      - rtl/rv_regfile.sv
      - rtl/rv_csr_file.sv
      - rtl/rv_idex_regs.sv
      - rtl/rv_alu_stage.sv
      - rtl/rv_core_slice_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/rv_core_slice_chk.sv
      - tb/tb_rv_core_slice.sv
